/* filelist.f */
+incdir+verification
verilog/pwl_pkg.sv
verilog/pwl_seg_rx.sv
verilog/pwl_isqrt.sv
verilog/pwl_sqrt_seg.sv
verilog/pwl_seg_tx.sv
verilog/pwl_sqrt_top.sv
verification/tb_pwl_sqrt.sv

/* Bender.yml */
package:
  name: pwl_sqrt

sources:
  - verilog/pwl_pkg.sv
  - verilog/pwl_seg_rx.sv
  - verilog/pwl_isqrt.sv
  - verilog/pwl_sqrt_seg.sv
  - verilog/pwl_seg_tx.sv
  - verilog/pwl_sqrt_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_pwl_sqrt.sv

/* verification/pwl_sqrt_model.svh */
/*
  reference model for the testbench; include inside the testbench module
  model_expand pushes {t, len, y0, y1} per expected output piece
*/
`ifndef PWL_SQRT_MODEL_SVH
`define PWL_SQRT_MODEL_SVH

function automatic logic [pwl_pkg::Y_W-1:0] model_isqrt(input logic [pwl_pkg::U_W-1:0] u);
  logic [pwl_pkg::Y_W-1:0] r;
  logic [pwl_pkg::Y_W-1:0] cand;
  r = '0;
  for (int i = pwl_pkg::Y_W - 1; i >= 0; i--) begin
    cand = r | (pwl_pkg::Y_W'(1) << i);
    if (64'(cand) * 64'(cand) <= 64'(u)) r = cand; // keep bit if square fits
  end
  return r;
endfunction

function automatic logic [pwl_pkg::U_W-1:0] model_radicand(
  input logic [pwl_pkg::A_W-1:0] a, input logic signed [pwl_pkg::B_W-1:0] b,
  input logic [pwl_pkg::LEN_W-1:0] t);
  longint acc;
  acc = longint'(a) + longint'(b) * longint'(t);
  return (acc < 0) ? '0 : pwl_pkg::U_W'(acc); // clamp at zero
endfunction

function automatic int model_step_k(input logic [pwl_pkg::U_W-1:0] u);
  int msb;
  int k;
  msb = 0;
  for (int i = 0; i < pwl_pkg::U_W; i++) if (u[i]) msb = i;
  k = (msb >> 1) - pwl_pkg::TOL_SHIFT;
  return (k < 0) ? 0 : ((k > pwl_pkg::K_MAX) ? pwl_pkg::K_MAX : k);
endfunction

function automatic void model_expand(
  input logic [pwl_pkg::A_W-1:0] a, input logic signed [pwl_pkg::B_W-1:0] b,
  input logic [pwl_pkg::LEN_W-1:0] len, inout logic [pwl_pkg::T_W-1:0] t,
  ref logic [pwl_pkg::T_W+pwl_pkg::LEN_W+2*pwl_pkg::Y_W-1:0] q[$]);
  int off;
  int plen;
  logic [pwl_pkg::U_W-1:0] u;
  logic [pwl_pkg::Y_W-1:0] y0;
  logic [pwl_pkg::Y_W-1:0] y1;
  off = 0;
  u   = model_radicand(a, b, '0);
  y0  = model_isqrt(u);
  while (off < len) begin
    plen = 1 << model_step_k(u);
    if (plen > len - off) plen = len - off; // clip to ticks left
    off  = off + plen;
    u    = model_radicand(a, b, pwl_pkg::LEN_W'(off));
    y1   = model_isqrt(u);
    q.push_back({t, pwl_pkg::LEN_W'(plen), y0, y1});
    t    = t + pwl_pkg::T_W'(plen);
    y0   = y1;
  end
endfunction

`endif

/* verification/tb_pwl_sqrt.sv */
/*
  testbench for the PWL square-root stage; random segments from a fixed seed,
  credits handled on both sides, every output checked against the included model
*/
`timescale 1ns/100ps

module tb_pwl_sqrt;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           in_valid;
  logic [pwl_pkg::A_W-1:0]        in_a;
  logic signed [pwl_pkg::B_W-1:0] in_b;
  logic [pwl_pkg::LEN_W-1:0]      in_len;
  logic                           in_credit;
  logic                           out_valid;
  logic [pwl_pkg::T_W-1:0]        out_t;
  logic [pwl_pkg::LEN_W-1:0]      out_len;
  logic [pwl_pkg::Y_W-1:0]        out_y0;
  logic [pwl_pkg::Y_W-1:0]        out_y1;
  logic                           out_credit = 1'b0;

  integer seed = 32'hee2a_39ee;
  logic [pwl_pkg::T_W+pwl_pkg::LEN_W+2*pwl_pkg::Y_W-1:0] exp_q[$]; // {t, len, y0, y1}
  logic [pwl_pkg::LEN_W-1:0] seg_len_q[$];  // input lengths not yet fully seen
  logic [pwl_pkg::T_W-1:0]   model_t = '0;  // model start time of next piece
  logic [pwl_pkg::T_W-1:0]   next_t  = '0;  // out_t implied by the previous piece
  int          len_acc  = 0;                // output ticks of the open input segment
  int          up_cred  = pwl_pkg::RX_DEPTH;
  int          owed     = 0;                // downstream credits still to give back
  int          hold_cnt = 0;                // cycles left in a credit hold
  bit          bp_mode  = 1'b0;             // long credit holds on
  int unsigned cr_r;
  int          errs = 0;
  int          checks = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;

  `include "pwl_sqrt_model.svh"

  pwl_sqrt_top i_dut (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_len(in_len), .in_credit(in_credit),
    .out_valid(out_valid), .out_t(out_t), .out_len(out_len),
    .out_y0(out_y0), .out_y1(out_y1), .out_credit(out_credit)
  );

  always #4 clk = ~clk; // 8 ns period

  function automatic int unsigned rnd();
    return $unsigned($random(seed));
  endfunction

  task automatic check_time(input logic [pwl_pkg::T_W-1:0] got,
                            input logic [pwl_pkg::T_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input logic [pwl_pkg::LEN_W-1:0] got,
                           input logic [pwl_pkg::LEN_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_value(input logic [pwl_pkg::Y_W-1:0] got,
                             input logic [pwl_pkg::Y_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // one output piece against the queue head
  task automatic check_output();
    logic [pwl_pkg::T_W-1:0]   e_t;
    logic [pwl_pkg::LEN_W-1:0] e_len;
    logic [pwl_pkg::Y_W-1:0]   e_y0;
    logic [pwl_pkg::Y_W-1:0]   e_y1;
    if (exp_q.size() == 0) begin
      errs++;
      $display("error at %0t: output segment arrived with nothing expected", $time);
      return;
    end
    {e_t, e_len, e_y0, e_y1} = exp_q.pop_front();
    check_time(out_t, e_t, "out_t");
    check_len(out_len, e_len, "out_len");
    check_value(out_y0, e_y0, "out_y0");
    check_value(out_y1, e_y1, "out_y1");
    check_time(out_t, next_t, "time continuity");
    next_t  = out_t + pwl_pkg::T_W'(out_len);
    len_acc += out_len;
    if (seg_len_q.size() != 0 && len_acc >= seg_len_q[0]) begin
      check_len(pwl_pkg::LEN_W'(len_acc), seg_len_q.pop_front(), "segment length sum");
      len_acc = 0;
    end
  endtask

  // sampled at the edge, values are the settled ones
  always @(posedge clk) begin
    if (rst_n && in_credit) begin
      up_cred++;
      if (up_cred > pwl_pkg::RX_DEPTH) begin
        errs++;
        $display("error at %0t: upstream credit count rose above the fifo depth", $time);
      end
    end
    if (rst_n && out_valid) begin
      owed++;               // DUT spent one downstream credit
      check_output();
    end
  end

  // downstream credit return, random gaps and long holds under back-pressure
  always begin
    @(posedge clk);
    cr_r = rnd();           // drawn at the edge, stimulus draws 1 ns later
    #1;
    out_credit = 1'b0;
    if (hold_cnt > 0) begin
      hold_cnt--;
    end else if (bp_mode && (cr_r % 256) == 0) begin
      hold_cnt = 100 + (cr_r >> 8) % 400;
    end else if (rst_n && owed > 0 && ((cr_r >> 20) % 3) == 0) begin
      out_credit = 1'b1;
      owed--;
    end
  end

  // caller sits 1 ns after an edge
  task automatic send_segment(input logic [pwl_pkg::A_W-1:0] a,
                              input logic signed [pwl_pkg::B_W-1:0] b,
                              input logic [pwl_pkg::LEN_W-1:0] len);
    int waited;
    waited = 0;
    while (up_cred <= 0) begin   // never send without a credit
      @(posedge clk);
      #1;
      waited++;
      if (waited > 200000) abort_run("no upstream credit came back");
    end
    model_expand(a, b, len, model_t, exp_q);
    seg_len_q.push_back(len);
    in_valid = 1'b1;
    in_a     = a;
    in_b     = b;
    in_len   = len;
    up_cred--;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // mode 0 constant, 1 rising, 2 falling through zero, 3 any of them
  task automatic gen_segment(input int mode);
    int unsigned r0;
    int unsigned r1;
    int unsigned r2;
    int unsigned r3;
    int unsigned mb;
    int m;
    logic [pwl_pkg::A_W-1:0]        a;
    logic signed [pwl_pkg::B_W-1:0] b;
    logic [pwl_pkg::LEN_W-1:0]      len;
    m  = (mode == 3) ? int'(rnd() % 3) : mode;
    r0 = rnd();
    r1 = rnd();
    r2 = rnd();
    r3 = rnd();
    len = pwl_pkg::LEN_W'(1 + r2 % 600);
    a   = pwl_pkg::A_W'(r0 >> (r1 % 24));   // spread over small and large values
    b   = '0;
    if (m == 1) begin
      b = pwl_pkg::B_W'(1 + ((r3 % 32767) >> (r1 % 15)));
    end else if (m == 2) begin
      mb  = 1 + r0 % 1000;
      len = pwl_pkg::LEN_W'(1 + r2 % 300);
      a   = pwl_pkg::A_W'(mb * (r1 % len) + r3 % mb); // zero crossing inside
      b   = -$signed(pwl_pkg::B_W'(mb));
    end
    send_segment(a, b, len);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || up_cred != pwl_pkg::RX_DEPTH) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 2000000) abort_run("expected outputs never arrived");
    end
  endtask

  task automatic run_test(input string name, input int mode, input int n, input bit bp);
    int e0;
    e0      = errs;
    bp_mode = bp;
    for (int i = 0; i < n; i++) begin
      gen_segment(mode);
      if (rnd() % 8 == 0) repeat (rnd() % 20) begin  // occasional idle gap
        @(posedge clk);
        #1;
      end
    end
    wait_drain();
    bp_mode = 1'b0;
    if (errs == e0) begin
      tests_pass++;
      $display("test %-14s passed, %0d segments", name, n);
    end else begin
      tests_fail++;
      $display("test %-14s failed, %0d errors", name, errs - e0);
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_a     = '0;
    in_b     = '0;
    in_len   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_test("constant", 0, 20, 1'b0);
    run_test("rising", 1, 20, 1'b0);
    run_test("falling", 2, 20, 1'b0);
    run_test("continuity", 3, 20, 1'b0);
    run_test("backpressure", 3, 30, 1'b1);
    run_test("random_mix", 3, 200, 1'b0);
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_pass, tests_fail, checks, errs);
    if (tests_fail == 0 && errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/pwl_sqrt_top.sv */
/*
  top level of the PWL square-root stage
  credit-based segment input, sqrt processing, credit-based segment output
*/
`timescale 1ns/100ps

module pwl_sqrt_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  input  logic [pwl_pkg::A_W-1:0]         in_a,
  input  logic signed [pwl_pkg::B_W-1:0]  in_b,
  input  logic [pwl_pkg::LEN_W-1:0]       in_len,
  output logic                            in_credit,
  output logic                            out_valid,
  output logic [pwl_pkg::T_W-1:0]         out_t,
  output logic [pwl_pkg::LEN_W-1:0]       out_len,
  output logic [pwl_pkg::Y_W-1:0]         out_y0,
  output logic [pwl_pkg::Y_W-1:0]         out_y1,
  input  logic                            out_credit
);

  // fifo head to processing
  logic                           rx_valid;
  logic [pwl_pkg::A_W-1:0]        rx_a;
  logic signed [pwl_pkg::B_W-1:0] rx_b;
  logic [pwl_pkg::LEN_W-1:0]      rx_len;
  logic                           rx_pop;

  // pieces to output side
  logic                       pc_valid;
  logic [pwl_pkg::T_W-1:0]    pc_t;
  logic [pwl_pkg::LEN_W-1:0]  pc_len;
  logic [pwl_pkg::Y_W-1:0]    pc_y0;
  logic [pwl_pkg::Y_W-1:0]    pc_y1;
  logic                       pc_ready;

  pwl_seg_rx i_rx (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_a(in_a), .in_b(in_b), .in_len(in_len), .in_credit(in_credit),
    .rx_valid(rx_valid), .rx_a(rx_a), .rx_b(rx_b), .rx_len(rx_len), .rx_pop(rx_pop)
  );

  pwl_sqrt_seg i_seg (
    .clk(clk), .rst_n(rst_n),
    .rx_valid(rx_valid), .rx_a(rx_a), .rx_b(rx_b), .rx_len(rx_len), .rx_pop(rx_pop),
    .pc_valid(pc_valid), .pc_t(pc_t), .pc_len(pc_len),
    .pc_y0(pc_y0), .pc_y1(pc_y1), .pc_ready(pc_ready)
  );

  pwl_seg_tx i_tx (
    .clk(clk), .rst_n(rst_n),
    .pc_valid(pc_valid), .pc_t(pc_t), .pc_len(pc_len),
    .pc_y0(pc_y0), .pc_y1(pc_y1), .pc_ready(pc_ready),
    .out_valid(out_valid), .out_t(out_t), .out_len(out_len),
    .out_y0(out_y0), .out_y1(out_y1), .out_credit(out_credit)
  );

endmodule

/* verilog/pwl_seg_tx.sv */
/*
  output side; one output register and a credit counter toward downstream
  a piece is sent when the register is full and a credit is left
*/
`timescale 1ns/100ps

module pwl_seg_tx (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pc_valid,
  input  logic [pwl_pkg::T_W-1:0]    pc_t,
  input  logic [pwl_pkg::LEN_W-1:0]  pc_len,
  input  logic [pwl_pkg::Y_W-1:0]    pc_y0,
  input  logic [pwl_pkg::Y_W-1:0]    pc_y1,
  output logic                       pc_ready,
  output logic                       out_valid,
  output logic [pwl_pkg::T_W-1:0]    out_t,
  output logic [pwl_pkg::LEN_W-1:0]  out_len,
  output logic [pwl_pkg::Y_W-1:0]    out_y0,
  output logic [pwl_pkg::Y_W-1:0]    out_y1,
  input  logic                       out_credit  // one credit per pulse
);

  logic                       full;  // output register holds a piece
  logic [pwl_pkg::TXC_W-1:0]  cnt;   // downstream credits held
  logic                       load;

  assign pc_ready  = !full;
  assign load      = pc_valid && pc_ready;
  assign out_valid = full && (cnt != '0); // full clears on send, so one cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
      cnt  <= pwl_pkg::TXC_W'(pwl_pkg::TX_CREDITS);
    end else begin
      if (load) begin
        full <= 1'b1;
      end else if (out_valid) begin
        full <= 1'b0;
      end
      if (out_credit && !out_valid) begin
        cnt <= cnt + 1'b1;
      end else if (!out_credit && out_valid) begin
        cnt <= cnt - 1'b1;   // spend one
      end
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (load) begin
      out_t   <= pc_t;
      out_len <= pc_len;
      out_y0  <= pc_y0;
      out_y1  <= pc_y1;
    end
  end

  // downstream never returns more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    cnt <= pwl_pkg::TX_CREDITS);

endmodule

/* verilog/pwl_sqrt_seg.sv */
/*
  processing part; splits each input segment into pieces sized by the square-root
  curvature and emits start time, length, start root and end root per piece
*/
`timescale 1ns/100ps

module pwl_sqrt_seg (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rx_valid,
  input  logic [pwl_pkg::A_W-1:0]         rx_a,
  input  logic signed [pwl_pkg::B_W-1:0]  rx_b,
  input  logic [pwl_pkg::LEN_W-1:0]       rx_len,
  output logic                            rx_pop,
  output logic                            pc_valid,
  output logic [pwl_pkg::T_W-1:0]         pc_t,   // absolute tick counter
  output logic [pwl_pkg::LEN_W-1:0]       pc_len,
  output logic [pwl_pkg::Y_W-1:0]         pc_y0,
  output logic [pwl_pkg::Y_W-1:0]         pc_y1,
  input  logic                            pc_ready
);

  pwl_pkg::seg_state_e state;

  logic [pwl_pkg::A_W-1:0]        seg_a;
  logic signed [pwl_pkg::B_W-1:0] seg_b;
  logic [pwl_pkg::LEN_W-1:0]      seg_left; // ticks not yet covered
  logic [pwl_pkg::LEN_W-1:0]      off;      // offset of piece start in segment
  logic [pwl_pkg::U_W-1:0]        u_cur;    // radicand at piece start

  logic                      sq_start;
  logic [pwl_pkg::U_W-1:0]   sq_arg;     // also holds the end radicand of the piece
  logic                      sq_done;
  logic [pwl_pkg::Y_W-1:0]   sq_root;

  logic [pwl_pkg::K_W-1:0]   k_sel;
  logic [pwl_pkg::LEN_W-1:0] step;
  logic [pwl_pkg::LEN_W-1:0] plen;
  logic [pwl_pkg::U_W-1:0]   u_end;
  logic                      xfer;

  // k = clamp((msb(u) >> 1) - TOL_SHIFT, 0, K_MAX)
  function automatic logic [pwl_pkg::K_W-1:0] step_k(input logic [pwl_pkg::U_W-1:0] u);
    int msb;
    int k;
    msb = 0;                 // zero radicand counts as msb 0
    for (int i = 0; i < pwl_pkg::U_W; i++) begin
      if (u[i]) msb = i;
    end
    k = (msb >> 1) - pwl_pkg::TOL_SHIFT;
    if (k < 0) k = 0;
    if (k > pwl_pkg::K_MAX) k = pwl_pkg::K_MAX;
    return pwl_pkg::K_W'(k);
  endfunction

  // a + b*off, negative clamps to zero
  function automatic logic [pwl_pkg::U_W-1:0] radicand(
    input logic [pwl_pkg::A_W-1:0]        a,
    input logic signed [pwl_pkg::B_W-1:0] b,
    input logic [pwl_pkg::LEN_W-1:0]      t
  );
    logic signed [pwl_pkg::U_W+1:0] acc;
    acc = $signed({{(pwl_pkg::U_W + 2 - pwl_pkg::A_W){1'b0}}, a}) + b * $signed({1'b0, t});
    if (acc < 0) return '0;
    return acc[pwl_pkg::U_W-1:0]; // max a + b*t stays below 2^32
  endfunction

  assign k_sel = step_k(u_cur);
  assign step  = pwl_pkg::LEN_W'(1) << k_sel;
  assign plen  = (step < seg_left) ? step : seg_left; // clip to ticks left
  assign u_end = radicand(seg_a, seg_b, off + plen);

  assign pc_valid = (state == pwl_pkg::S_EMIT);
  assign xfer     = pc_valid && pc_ready;
  assign rx_pop   = xfer && (seg_left == pc_len); // last piece of the segment

  pwl_isqrt i_isqrt (
    .clk      (clk),
    .rst_n    (rst_n),
    .sq_start (sq_start),
    .sq_arg   (sq_arg),
    .sq_done  (sq_done),
    .sq_root  (sq_root)
  );

  // FSM and time counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= pwl_pkg::S_IDLE;
      pc_t     <= '0;
      sq_start <= 1'b0;
    end else begin
      sq_start <= 1'b0;
      case (state)
        pwl_pkg::S_IDLE: if (rx_valid) begin
          sq_start <= 1'b1;          // root of a
          state    <= pwl_pkg::S_ROOT0;
        end
        pwl_pkg::S_ROOT0: if (sq_done) state <= pwl_pkg::S_PIECE;
        pwl_pkg::S_PIECE: begin
          sq_start <= 1'b1;          // root of end radicand
          state    <= pwl_pkg::S_ROOT1;
        end
        pwl_pkg::S_ROOT1: if (sq_done) state <= pwl_pkg::S_EMIT;
        pwl_pkg::S_EMIT: if (xfer) begin
          pc_t  <= pc_t + pwl_pkg::T_W'(pc_len);
          state <= rx_pop ? pwl_pkg::S_IDLE : pwl_pkg::S_PIECE;
        end
        default: state <= pwl_pkg::S_IDLE;
      endcase
    end
  end

  // segment and piece payload
  always_ff @(posedge clk) begin
    case (state)
      pwl_pkg::S_IDLE: if (rx_valid) begin
        seg_a    <= rx_a;
        seg_b    <= rx_b;
        seg_left <= rx_len;
        off      <= '0;
        u_cur    <= pwl_pkg::U_W'(rx_a);  // offset 0 is never negative
        sq_arg   <= pwl_pkg::U_W'(rx_a);
      end
      pwl_pkg::S_ROOT0: if (sq_done) pc_y0 <= sq_root;
      pwl_pkg::S_PIECE: begin
        pc_len <= plen;
        sq_arg <= u_end;
      end
      pwl_pkg::S_ROOT1: if (sq_done) pc_y1 <= sq_root;
      pwl_pkg::S_EMIT: if (xfer) begin
        off      <= off + pc_len;
        seg_left <= seg_left - pc_len;
        u_cur    <= sq_arg;   // end of this piece starts the next
        pc_y0    <= pc_y1;
      end
      default: ;
    endcase
  end

  a_piece_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    pc_valid |-> (pc_len != '0));

endmodule

/* verilog/pwl_isqrt.sv */
/*
  restoring digit-by-digit integer square root, floor(sqrt(sq_arg))
  pulse sq_start once; sq_done pulses ISQRT_CYC cycles later with sq_root valid
*/
`timescale 1ns/100ps

module pwl_isqrt (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sq_start,
  input  logic [pwl_pkg::U_W-1:0]  sq_arg,
  output logic                     sq_done,
  output logic [pwl_pkg::Y_W-1:0]  sq_root
);

  logic [pwl_pkg::SQ_CNT_W-1:0] cnt;    // digits left, 0 idle
  logic [pwl_pkg::U_W-1:0]      arg;    // radicand bits still to shift in
  logic [pwl_pkg::Y_W+3:0]      rem;    // partial remainder
  logic [pwl_pkg::Y_W-1:0]      root;   // partial root
  logic [pwl_pkg::Y_W+3:0]      rem_sh; // remainder with next two bits
  logic [pwl_pkg::Y_W+3:0]      trial;  // 4*root + 1

  assign rem_sh  = {rem[pwl_pkg::Y_W+1:0], arg[pwl_pkg::U_W-1 -: 2]};
  assign trial   = {2'b00, root, 2'b01};
  assign sq_root = root;

  // sequencing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt     <= '0;
      sq_done <= 1'b0;
    end else begin
      sq_done <= 1'b0;
      if (sq_start) begin
        cnt <= pwl_pkg::SQ_CNT_W'(pwl_pkg::ISQRT_ITER);
      end else if (cnt != 0) begin
        cnt     <= cnt - 1'b1;
        sq_done <= (cnt == 1); // last digit lands with done
      end
    end
  end

  // one root digit per cycle
  always_ff @(posedge clk) begin
    if (sq_start) begin
      arg  <= sq_arg;
      rem  <= '0;
      root <= '0;
    end else if (cnt != 0) begin
      arg <= arg << 2;
      if (rem_sh >= trial) begin
        rem  <= rem_sh - trial;  // digit is 1
        root <= {root[pwl_pkg::Y_W-2:0], 1'b1};
      end else begin
        rem  <= rem_sh;          // restore, digit is 0
        root <= {root[pwl_pkg::Y_W-2:0], 1'b0};
      end
    end
  end

  // fixed latency that the processing FSM relies on
  a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    sq_start |-> ##(pwl_pkg::ISQRT_CYC) sq_done);

endmodule

/* verilog/pwl_seg_rx.sv */
/*
  input side of the stage; holds up to RX_DEPTH segments from upstream
  and hands one credit back for every entry that the processing part pops
*/
`timescale 1ns/100ps

module pwl_seg_rx (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,  // one cycle per segment
  input  logic [pwl_pkg::A_W-1:0]         in_a,
  input  logic signed [pwl_pkg::B_W-1:0]  in_b,
  input  logic [pwl_pkg::LEN_W-1:0]       in_len,
  output logic                            in_credit, // one pulse per freed entry
  output logic                            rx_valid,
  output logic [pwl_pkg::A_W-1:0]         rx_a,
  output logic signed [pwl_pkg::B_W-1:0]  rx_b,
  output logic [pwl_pkg::LEN_W-1:0]       rx_len,
  input  logic                            rx_pop
);

  // entry storage
  logic [pwl_pkg::A_W-1:0]        mem_a   [pwl_pkg::RX_DEPTH];
  logic signed [pwl_pkg::B_W-1:0] mem_b   [pwl_pkg::RX_DEPTH];
  logic [pwl_pkg::LEN_W-1:0]      mem_len [pwl_pkg::RX_DEPTH];

  logic [pwl_pkg::RX_PTR_W-1:0] wr_ptr;
  logic [pwl_pkg::RX_PTR_W-1:0] rd_ptr;
  logic [pwl_pkg::RX_CNT_W-1:0] count;   // entries held

  assign rx_valid = (count != '0);
  assign rx_a     = mem_a[rd_ptr];   // head shows right after the push edge
  assign rx_b     = mem_b[rd_ptr];
  assign rx_len   = mem_len[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      in_credit <= rx_pop; // credit back one cycle after the pop
      if (in_valid) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
      if (rx_pop) rd_ptr <= rd_ptr + 1'b1;
      if (in_valid && !rx_pop) begin
        count <= count + 1'b1;
      end else if (!in_valid && rx_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // payload write, no reset needed
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem_a[wr_ptr]   <= in_a;
      mem_b[wr_ptr]   <= in_b;
      mem_len[wr_ptr] <= in_len;
    end
  end

  // sender spends credits, so a full fifo never sees a push
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (count != pwl_pkg::RX_DEPTH));

  // processing side pops only a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rx_pop |-> rx_valid);

  a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (in_len != '0));

endmodule

/* verilog/pwl_pkg.sv */
/*
  shared widths, sizes and the FSM state enum for the PWL square-root stage
  other files reach these by pwl_pkg:: scoped names
*/
package pwl_pkg;

  // segment field widths
  localparam int A_W   = 24; // start value a, unsigned
  localparam int B_W   = 16; // slope per tick, signed
  localparam int LEN_W = 16; // segment length in ticks
  localparam int U_W   = 32; // radicand
  localparam int Y_W   = 16; // root value
  localparam int T_W   = 32; // absolute tick time

  // input fifo and credits
  localparam int RX_DEPTH = 4;                      // also upstream credits after reset
  localparam int RX_PTR_W = $clog2(RX_DEPTH);
  localparam int RX_CNT_W = $clog2(RX_DEPTH + 1);
  localparam int TX_CREDITS = 2;                    // downstream credits after reset
  localparam int TXC_W    = $clog2(TX_CREDITS + 1);

  // piece length rule
  localparam int TOL_SHIFT = 2;  // error tolerance shift
  localparam int K_MAX     = 10; // largest step exponent
  localparam int K_W       = $clog2(K_MAX + 1);

  // isqrt sequencing
  localparam int ISQRT_ITER = U_W / 2;         // two radicand bits per cycle
  localparam int ISQRT_CYC  = ISQRT_ITER + 1;  // start to done
  localparam int SQ_CNT_W   = $clog2(ISQRT_CYC + 1);

  // processing FSM
  typedef enum logic [2:0] {
    S_IDLE,  // wait for fifo head
    S_ROOT0, // root of start radicand
    S_PIECE, // pick piece length, eval end radicand
    S_ROOT1, // root of end radicand
    S_EMIT   // hold piece until tx takes it
  } seg_state_e;

endpackage
